//--- logic/fifo_params.svh
// FIFO sizing macros shared by the design and its testbench
`ifndef FIFO_PARAMS_SVH
`define FIFO_PARAMS_SVH

// Storage geometry
`define FIFO_DEPTH 64                       // Slots in the storage array

// Address bits for one slot
// The pointers carry one bit more, used as the wrap bit
`define FIFO_MEM_ADDR_WIDTH 6               // log2 of FIFO_DEPTH

// Width of one stored word
`define FIFO_DATA_WIDTH 8                   // Payload bits per entry

// Half-empty threshold
// Flag is set while the unread count is at or below this value
`define FIFO_HALFEMPTY 4                    // Unread entries

`endif

//--- logic/fifo_pkg.sv
// FIFO package with the pointer, address and payload types
`include "fifo_params.svh"

package fifo_pkg;

    // Pointer with one wrap bit above the slot address
    // Equal pointers mean empty, a differing wrap bit with equal address means full
    typedef logic [`FIFO_MEM_ADDR_WIDTH:0] fifo_ptr_t;       // Address plus wrap bit

    // Slot address into the storage array
    typedef logic [`FIFO_MEM_ADDR_WIDTH-1:0] fifo_addr_t;    // Low bits of a pointer

    // One stored entry
    typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_word_t;        // Default payload

endpackage

//--- logic/fifo_mem_if.sv
// Storage port bundle between the write control, read control and memory array
`timescale 1ns/1ps
`include "fifo_params.svh"

interface fifo_mem_if
    import fifo_pkg::*;
();

    // Write port, owned by the write control
    logic       w_enable;                   // Store write_data this edge
    fifo_addr_t write_addr;                 // Slot being written
    fifo_word_t write_data;                 // Word being written

    // Read port, address side owned by the read control
    logic       r_enable;                   // Load read_data this edge
    fifo_addr_t read_addr;                  // Slot being read

    // Registered output of the array
    fifo_word_t read_data;                  // Held until the next read

    modport write_side (
        output w_enable,
        output write_addr,
        output write_data
    );

    modport read_side (
        output r_enable,
        output read_addr
    );

    modport memory (                        // Array sees both ports
        input  w_enable, write_addr, write_data,
        input  r_enable, read_addr,
        output read_data
    );

endinterface

//--- logic/write_control.sv
// Write control: write pointer, full flag, write enable and write acknowledge
`timescale 1ns/1ps
`include "fifo_params.svh"

module write_control
    import fifo_pkg::*;
(
    input  logic           clk_read_logic,  // Single FIFO clock
    input  logic           reset,           // Asynchronous, active high
    input  logic           write_request,   // Level strobe from the producer
    input  fifo_word_t     write_data,      // Word offered with the strobe
    input  fifo_ptr_t      read_pointer,    // From the read control, for the full test
    fifo_mem_if.write_side mem,             // Write port of the array
    output fifo_ptr_t      write_pointer,   // Next slot to fill, with wrap bit
    output logic           write_ack,       // One-cycle pulse after an accepted write
    output logic           full_fifo_status // All slots hold unread data
);

    logic       addr_match;                 // Slot addresses equal
    logic       wrap_differs;               // Writer is one lap ahead
    logic       w_enable;                   // Accepted write this cycle
    fifo_addr_t wr_addr;                    // Slot part of the write pointer

    assign wr_addr = write_pointer[`FIFO_MEM_ADDR_WIDTH-1:0];

    // Full when the writer has gone exactly one lap past the reader
    assign addr_match = (wr_addr == read_pointer[`FIFO_MEM_ADDR_WIDTH-1:0]);
    assign wrap_differs = (write_pointer[`FIFO_MEM_ADDR_WIDTH] !=
                           read_pointer[`FIFO_MEM_ADDR_WIDTH]);
    assign full_fifo_status = addr_match && wrap_differs;

    // A request against a full FIFO is dropped, not held
    assign w_enable = write_request && !full_fifo_status;

    // Drive the array write port
    assign mem.w_enable   = w_enable;       // Array stores on the same edge
    assign mem.write_addr = wr_addr;        // Current slot
    assign mem.write_data = write_data;     // Producer data passes straight in

    // Pointer and acknowledge move together on the accepting edge
    always_ff @(posedge clk_read_logic or posedge reset) begin
        if (reset) begin
            write_pointer <= '0;            // Start at slot 0, lap 0
            write_ack     <= 1'b0;          // No pending acknowledge
        end else begin
            write_ack <= w_enable;          // High for one cycle per write
            if (w_enable) begin
                write_pointer <= write_pointer + 1'b1; // Wraps into the lap bit
            end
        end
    end

endmodule

//--- logic/fifo_memory.sv
// FIFO storage array with a synchronous write port and a registered read port
`timescale 1ns/1ps
`include "fifo_params.svh"

module fifo_memory
    import fifo_pkg::*;
#(
    parameter type data_t = fifo_word_t     // Payload held in each slot
) (
    input  logic       clk_read_logic,      // Single FIFO clock
    input  logic       reset,               // Clears the output register only
    fifo_mem_if.memory mem                  // Both ports of the array
);

    data_t mem_array [`FIFO_DEPTH];         // Storage, no reset
    data_t rd_data_q;                       // Output register

    // Write port
    // Full blocks the writer, so a write never lands on an unread slot
    always_ff @(posedge clk_read_logic) begin
        if (mem.w_enable) begin
            mem_array[mem.write_addr] <= mem.write_data;
        end
    end

    // Read port
    // Loads only on an accepted read and holds otherwise
    always_ff @(posedge clk_read_logic or posedge reset) begin
        if (reset) begin
            rd_data_q <= '0;                // Known value before the first read
        end else if (mem.r_enable) begin
            rd_data_q <= mem_array[mem.read_addr]; // Valid with read_ack
        end
    end

    assign mem.read_data = rd_data_q;       // Back out through the bundle

endmodule

//--- logic/read_control.sv
// Read control: read pointer, empty and half-empty flags, read enable and read acknowledge
`timescale 1ns/1ps
`include "fifo_params.svh"

module read_control
    import fifo_pkg::*;
(
    input  logic          clk_read_logic,   // Single FIFO clock
    input  logic          reset,            // Asynchronous, active high
    input  logic          read_request,     // Level strobe from the consumer
    input  fifo_ptr_t     write_pointer,    // From the write control
    fifo_mem_if.read_side mem,              // Read port of the array
    output fifo_ptr_t     read_pointer,     // Next slot to drain, with wrap bit
    output logic          read_ack,         // One-cycle pulse, read_data valid with it
    output logic          empty_fifo_status,     // No unread entries
    output logic          halfempty_fifo_status  // Unread count at or below threshold
);

    localparam fifo_ptr_t HALFEMPTY_LIMIT = fifo_ptr_t'(`FIFO_HALFEMPTY);

    logic       r_enable;                   // Accepted read this cycle
    fifo_ptr_t  fill_count;                 // Unread entries, 0 to FIFO_DEPTH
    fifo_addr_t rd_addr;                    // Slot part of the read pointer

    assign rd_addr = read_pointer[`FIFO_MEM_ADDR_WIDTH-1:0];

    // Empty at any position where the pointers meet, wrap bit included
    assign empty_fifo_status = (read_pointer == write_pointer);

    // Modulo difference stays correct across the wrap
    // The extra pointer bit lets it reach FIFO_DEPTH
    assign fill_count = write_pointer - read_pointer;

    // A request against an empty FIFO is dropped, not held
    assign r_enable = read_request && !empty_fifo_status;

    // Drive the array read port
    assign mem.r_enable  = r_enable;        // Array loads read_data this edge
    assign mem.read_addr = rd_addr;         // Oldest unread slot

    // Pointer and acknowledge follow an accepted read by one edge
    always_ff @(posedge clk_read_logic or posedge reset) begin
        if (reset) begin
            read_pointer <= '0;             // Start at slot 0, lap 0
            read_ack     <= 1'b0;           // No pending acknowledge
        end else begin
            read_ack <= r_enable;           // Lines up with the new read_data
            if (r_enable) begin
                read_pointer <= read_pointer + 1'b1; // Wraps into the lap bit
            end
        end
    end

    // Half-empty is sampled from the count before this edge,
    // so the flag trails the count by one cycle
    always_ff @(posedge clk_read_logic or posedge reset) begin
        if (reset) begin
            halfempty_fifo_status <= 1'b1;  // Empty counts as half empty
        end else begin
            halfempty_fifo_status <= (fill_count <= HALFEMPTY_LIMIT);
        end
    end

endmodule

//--- logic/sync_fifo.sv
// Synchronous 64 by 8 FIFO joining the write control, storage array and read control
`timescale 1ns/1ps
`include "fifo_params.svh"

module sync_fifo
    import fifo_pkg::*;
(
    input  logic                        clk_read_logic,   // Single FIFO clock
    input  logic                        reset,            // Asynchronous, active high

    // Producer side
    input  logic                        write_request,    // Level strobe
    input  logic [`FIFO_DATA_WIDTH-1:0] write_data,       // Word to store
    output logic                        write_ack,        // Pulse after an accepted write
    output logic                        full_fifo_status, // Writes are dropped while set

    // Consumer side
    input  logic                        read_request,     // Level strobe
    output logic [`FIFO_DATA_WIDTH-1:0] read_data,        // Valid with read_ack
    output logic                        read_ack,         // Pulse after an accepted read
    output logic                        empty_fifo_status,     // Reads are dropped while set
    output logic                        halfempty_fifo_status  // Lags the count by a cycle
);

    fifo_ptr_t write_pointer;               // Write control to read control
    fifo_ptr_t read_pointer;                // Read control to write control

    fifo_mem_if mem_bus ();                 // Array ports shared by all three blocks

    // Input side
    write_control u_write_control (
        .clk_read_logic   (clk_read_logic),
        .reset            (reset),
        .write_request    (write_request),
        .write_data       (write_data),
        .read_pointer     (read_pointer),
        .mem              (mem_bus.write_side),
        .write_pointer    (write_pointer),
        .write_ack        (write_ack),
        .full_fifo_status (full_fifo_status)
    );

    // Storage, holding the default payload type
    fifo_memory #(
        .data_t (fifo_word_t)
    ) u_fifo_memory (
        .clk_read_logic (clk_read_logic),
        .reset          (reset),
        .mem            (mem_bus.memory)
    );

    // Output side
    read_control u_read_control (
        .clk_read_logic        (clk_read_logic),
        .reset                 (reset),
        .read_request          (read_request),
        .write_pointer         (write_pointer),
        .mem                   (mem_bus.read_side),
        .read_pointer          (read_pointer),
        .read_ack              (read_ack),
        .empty_fifo_status     (empty_fifo_status),
        .halfempty_fifo_status (halfempty_fifo_status)
    );

    assign read_data = mem_bus.read_data;   // Registered word from the array

endmodule

//--- tb/tb_sync_fifo.sv
// Testbench for the synchronous FIFO with random stimulus, a queue model and assertion checks
`timescale 1ns/1ps
`include "fifo_params.svh"

module tb_sync_fifo
    import fifo_pkg::*;
();

    localparam int CLK_HALF_NS   = 4;       // 8 ns period
    localparam int DRIVE_SKEW_NS = 1;       // Inputs move after the edge
    localparam int RESET_CYCLES  = 5;
    localparam int RANDOM_CYCLES = 2000;    // Length of mixed traffic
    localparam int PHASE_CYCLES  = 250;     // Bias flips between fill and drain
    localparam int WAIT_LIMIT    = 80;      // Cycles allowed for full or empty to appear
    localparam int WATCHDOG_NS   = 200000;  // Whole-run limit

    // DUT ports
    logic       clk_read_logic;
    logic       reset;
    logic       write_request;
    fifo_word_t write_data;
    logic       write_ack;
    logic       full_fifo_status;
    logic       read_request;
    fifo_word_t read_data;
    logic       read_ack;
    logic       empty_fifo_status;
    logic       halfempty_fifo_status;

    // Reference model
    fifo_word_t model_q [$];                // Unread words, oldest first
    int         model_count;                // Unread entries after the last edge
    logic       model_write;                // Write taken at this edge
    logic       model_read;                 // Read taken at this edge
    logic       exp_write_ack;
    logic       exp_read_ack;
    fifo_word_t exp_read_data;              // Word popped by the last accepted read
    logic       exp_halfempty;              // Count test from one edge earlier
    logic       exp_empty;
    logic       exp_full;

    int error_count;
    int tests_run;
    int tests_failed;

    sync_fifo u_sync_fifo (
        .clk_read_logic        (clk_read_logic),
        .reset                 (reset),
        .write_request         (write_request),
        .write_data            (write_data),
        .write_ack             (write_ack),
        .full_fifo_status      (full_fifo_status),
        .read_request          (read_request),
        .read_data             (read_data),
        .read_ack              (read_ack),
        .empty_fifo_status     (empty_fifo_status),
        .halfempty_fifo_status (halfempty_fifo_status)
    );

    initial begin
        clk_read_logic = 1'b0;
        forever #CLK_HALF_NS clk_read_logic = ~clk_read_logic;
    end

    initial begin                           // Guards against a stuck run
        #WATCHDOG_NS;
        $display("run did not finish within %0d ns", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    // Model follows the handshake rules where each flag blocks only its own side
    always @(posedge clk_read_logic or posedge reset) begin
        if (reset) begin
            model_q.delete();
            model_count   <= 0;
            exp_write_ack <= 1'b0;
            exp_read_ack  <= 1'b0;
            exp_read_data <= '0;            // Output register clears on reset
            exp_halfempty <= 1'b1;
        end else begin
            model_write = write_request && (model_count < `FIFO_DEPTH);
            model_read  = read_request && (model_count > 0);
            exp_write_ack <= model_write;   // Pulse one cycle later
            exp_read_ack  <= model_read;
            exp_halfempty <= (model_count <= `FIFO_HALFEMPTY);
            if (model_read) begin
                exp_read_data <= model_q.pop_front(); // Head word goes out with read_ack
            end
            if (model_write) begin
                model_q.push_back(write_data);
            end
            model_count <= model_count + int'(model_write) - int'(model_read);
        end
    end

    assign exp_empty = (model_count == 0);  // Flags follow the count with no lag
    assign exp_full  = (model_count == `FIFO_DEPTH);

    // Cycle checks against the model
    a_write_ack: assert property (@(posedge clk_read_logic) disable iff (reset)
        write_ack == exp_write_ack)
        else report_mismatch("write_ack", int'($sampled(exp_write_ack)),
                             int'($sampled(write_ack)));

    a_read_ack: assert property (@(posedge clk_read_logic) disable iff (reset)
        read_ack == exp_read_ack)
        else report_mismatch("read_ack", int'($sampled(exp_read_ack)),
                             int'($sampled(read_ack)));

    a_read_data: assert property (@(posedge clk_read_logic) disable iff (reset)
        read_data == exp_read_data)         // Held between reads as well
        else report_mismatch("read_data", int'($sampled(exp_read_data)),
                             int'($sampled(read_data)));

    a_empty: assert property (@(posedge clk_read_logic) disable iff (reset)
        empty_fifo_status == exp_empty)
        else report_mismatch("empty_fifo_status", int'($sampled(exp_empty)),
                             int'($sampled(empty_fifo_status)));

    a_full: assert property (@(posedge clk_read_logic) disable iff (reset)
        full_fifo_status == exp_full)
        else report_mismatch("full_fifo_status", int'($sampled(exp_full)),
                             int'($sampled(full_fifo_status)));

    a_halfempty: assert property (@(posedge clk_read_logic) disable iff (reset)
        halfempty_fifo_status == exp_halfempty)
        else report_mismatch("halfempty_fifo_status", int'($sampled(exp_halfempty)),
                             int'($sampled(halfempty_fifo_status)));

    task automatic report_mismatch(input string name, input int exp, input int act);
        $display("FAIL t=%0t %s expected %0h got %0h", $time, name, exp, act);
        error_count++;
    endtask

    task automatic expect_value(input string name, input int exp, input int act);
        assert (exp == act) else report_mismatch(name, exp, act);
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests_run++;
        if (error_count == errors_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end
    endtask

    task automatic tick();                  // Next edge plus the drive skew
        @(posedge clk_read_logic);
        #DRIVE_SKEW_NS;
    endtask

    task automatic idle(input int cycles);
        write_request = 1'b0;
        read_request  = 1'b0;
        repeat (cycles) tick();
    endtask

    task automatic write_words(input int n); // Back to back writes with random payload
        for (int i = 0; i < n; i++) begin
            write_request = 1'b1;
            write_data    = fifo_word_t'($urandom);
            tick();
        end
        write_request = 1'b0;
    endtask

    task automatic read_words(input int n);
        for (int i = 0; i < n; i++) begin
            read_request = 1'b1;
            tick();
        end
        read_request = 1'b0;
    endtask

    task automatic fill_to_full(input int limit, output int writes);
        writes = 0;
        while (!full_fifo_status && writes < limit) begin
            write_request = 1'b1;
            write_data    = fifo_word_t'($urandom);
            tick();
            writes++;                       // Accepted since full was low when driven
        end
        write_request = 1'b0;
        if (!full_fifo_status) begin
            $display("full flag did not rise within %0d writes", limit);
            error_count++;
        end
    endtask

    task automatic drain_all(input int limit, output int reads);
        reads = 0;
        while (!empty_fifo_status && reads < limit) begin
            read_request = 1'b1;
            tick();
            reads++;
        end
        read_request = 1'b0;
        if (!empty_fifo_status) begin
            $display("empty flag did not rise within %0d reads", limit);
            error_count++;
        end
    endtask

    initial begin
        int  n_written;
        int  n_read;
        int  errs_at_start;
        bit  saw_full;
        bit  saw_empty;
        int  write_bias;

        void'($urandom(32'h6843_173f));
        reset         = 1'b1;
        write_request = 1'b0;
        write_data    = '0;
        read_request  = 1'b0;
        error_count   = 0;
        tests_run     = 0;
        tests_failed  = 0;

        // Reset state is checked while reset is held and again after release
        errs_at_start = error_count;
        repeat (RESET_CYCLES) @(posedge clk_read_logic);
        #DRIVE_SKEW_NS;
        expect_value("empty_fifo_status", 1, int'(empty_fifo_status));
        expect_value("full_fifo_status", 0, int'(full_fifo_status));
        expect_value("halfempty_fifo_status", 1, int'(halfempty_fifo_status));
        expect_value("write_ack", 0, int'(write_ack));
        expect_value("read_ack", 0, int'(read_ack));
        expect_value("read_data", 0, int'(read_data));
        reset = 1'b0;
        idle(2);
        expect_value("empty_fifo_status", 1, int'(empty_fifo_status));
        finish_test("reset_state", errs_at_start);

        // Order and data
        errs_at_start = error_count;
        n_written = $urandom_range(20, 40);
        write_words(n_written);
        idle(1);
        drain_all(WAIT_LIMIT, n_read);
        expect_value("reads_to_empty", n_written, n_read);
        idle(2);
        finish_test("order_and_data", errs_at_start);

        // Full FIFO drops an extra write
        errs_at_start = error_count;
        fill_to_full(WAIT_LIMIT, n_written);
        expect_value("writes_to_full", `FIFO_DEPTH, n_written);
        write_words(2);                     // Rejected with no write_ack
        idle(2);
        expect_value("full_fifo_status", 1, int'(full_fifo_status));
        drain_all(WAIT_LIMIT, n_read);
        expect_value("reads_to_empty", `FIFO_DEPTH, n_read);
        idle(2);
        finish_test("full", errs_at_start);

        // Empty FIFO with reads against it and pointers away from zero
        errs_at_start = error_count;
        read_words(3);                      // No read_ack expected
        idle(2);
        for (int lap = 0; lap < 3; lap++) begin
            write_words(45);                // Three laps carry both pointers past the wrap
            drain_all(WAIT_LIMIT, n_read);
            expect_value("reads_to_empty", 45, n_read);
            read_words(2);
            idle(1);
        end
        finish_test("empty", errs_at_start);

        // Half-empty through 1 to 6 entries and back down
        errs_at_start = error_count;
        for (int k = 1; k <= 6; k++) begin
            write_words(1);
            idle(2);                        // Register catches up with the count
            expect_value("halfempty_fifo_status", int'(k <= `FIFO_HALFEMPTY),
                         int'(halfempty_fifo_status));
        end
        for (int k = 5; k >= 0; k--) begin
            read_words(1);
            idle(2);
            expect_value("halfempty_fifo_status", int'(k <= `FIFO_HALFEMPTY),
                         int'(halfempty_fifo_status));
        end
        finish_test("halfempty", errs_at_start);

        // Simultaneous random traffic with phases that lean towards filling or draining
        errs_at_start = error_count;
        saw_full  = 1'b0;
        saw_empty = 1'b0;
        for (int cyc = 0; cyc < RANDOM_CYCLES; cyc++) begin
            write_bias    = ((cyc / PHASE_CYCLES) % 2 == 0) ? 75 : 25;
            write_request = ($urandom_range(0, 99) < write_bias);
            read_request  = ($urandom_range(0, 99) < (100 - write_bias));
            write_data    = fifo_word_t'($urandom);
            tick();
            if (full_fifo_status) begin
                saw_full = 1'b1;
            end
            if (empty_fifo_status) begin
                saw_empty = 1'b1;
            end
        end
        idle(1);
        drain_all(WAIT_LIMIT, n_read);
        idle(2);
        if (!saw_full || !saw_empty) begin
            $display("random traffic did not reach both full and empty");
            error_count++;
        end
        finish_test("random_traffic", errs_at_start);

        $display("tests run %0d, tests failed %0d, check errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+logic
logic/fifo_pkg.sv
logic/fifo_mem_if.sv
logic/write_control.sv
logic/fifo_memory.sv
logic/read_control.sv
logic/sync_fifo.sv
tb/tb_sync_fifo.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the FIFO testbench with Verilator, then judge the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f tb.f \
    --top-module tb_sync_fifo \
    -o tb_sync_fifo_sim

./obj_dir/tb_sync_fifo_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TESTS FAILED" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

if ! grep -q "TESTS PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
